/* filelist.f */
hw/convPkg.sv
hw/frameSequencer.sv
hw/columnBank.sv
hw/kernelConvolver.sv
hw/resultBuffer.sv
hw/convColumnTop.sv
tb/convColumnTb.sv

/* hw/columnBank.sv */
`timescale 1ns/1ps
`default_nettype none

module columnBank
    import convPkg::*;
(
    input  wire                  i_CLK,
    input  wire bankCtrl_t       i_bankCtrl,
    input  wire                  i_wrEn,
    input  wire  [NB_PIXEL-1:0]  i_pixel,
    output logic [NB_PIXEL-1:0]  o_pixel
);

    // one image column, row addressed
    logic [NB_PIXEL-1:0] pixelMem [BANK_DEPTH];

    always_ff @(posedge i_CLK) begin
        if (i_wrEn) begin
            pixelMem[i_bankCtrl.wrAddr] <= i_pixel;
        end
    end

    // registered read, one cycle behind the address
    always_ff @(posedge i_CLK) begin
        o_pixel <= pixelMem[i_bankCtrl.rdAddr];
    end

endmodule

`default_nettype wire

/* hw/convColumnTop.sv */
`timescale 1ns/1ps
`default_nettype none

module convColumnTop
    import convPkg::*;
(
    input  wire                          i_CLK,
    input  wire                          i_reset,
    input  wire                          i_load,
    input  wire                          i_SoP,
    input  wire                          i_pixValid,
    input  wire  [NB_PIXEL-1:0]          i_pixel,
    input  wire  [NB_ADDRESS-1:0]        i_imgLength,
    output wire  signed [NB_RESULT-1:0]  o_result,
    output wire                          o_EoP,
    output wire                          o_changeBlock
);

    wire bankCtrl_t                    bankCtrl;
    wire [NB_BANK_IDX-1:0]             oldestBank;
    wire                               convValid;
    wire                               resultValid;
    wire [NB_ADDRESS-1:0]              resultWrAddr;
    wire [NB_ADDRESS-1:0]              resultRdAddr;
    wire [NB_BANKS-1:0][NB_PIXEL-1:0]  bankPixels;
    wire signed [NB_RESULT-1:0]        convResult;

    frameSequencer uSequencer (
        .i_CLK          (i_CLK),
        .i_reset        (i_reset),
        .i_load         (i_load),
        .i_SoP          (i_SoP),
        .i_pixValid     (i_pixValid),
        .i_imgLength    (i_imgLength),
        .i_resultValid  (resultValid),
        .o_bankCtrl     (bankCtrl),
        .o_oldestBank   (oldestBank),
        .o_convValid    (convValid),
        .o_resultWrAddr (resultWrAddr),
        .o_resultRdAddr (resultRdAddr),
        .o_EoP          (o_EoP),
        .o_changeBlock  (o_changeBlock)
    );

    for (genvar b = 0; b < NB_BANKS; b++) begin : gBank
        columnBank uBank (
            .i_CLK      (i_CLK),
            .i_bankCtrl (bankCtrl),
            .i_wrEn     (bankCtrl.wrSel[b]),
            .i_pixel    (i_pixel),
            .o_pixel    (bankPixels[b])
        );
    end

    kernelConvolver uConvolver (
        .i_CLK         (i_CLK),
        .i_reset       (i_reset),
        .i_columns     (bankPixels),
        .i_oldestBank  (oldestBank),
        .i_valid       (convValid),
        .o_result      (convResult),
        .o_resultValid (resultValid)
    );

    resultBuffer uResults (
        .i_CLK    (i_CLK),
        .i_wrEn   (resultValid),
        .i_wrAddr (resultWrAddr),
        .i_wrData (convResult),
        .i_rdAddr (resultRdAddr),
        .o_rdData (o_result)
    );

endmodule

`default_nettype wire

/* hw/convPkg.sv */
`default_nettype none

package convPkg;

    // datapath widths
    localparam int NB_ADDRESS  = 10;
    localparam int NB_PIXEL    = 8;
    localparam int NB_COEF     = 4;
    localparam int NB_RESULT   = 20;
    localparam int NB_PRODUCT  = NB_PIXEL + 1 + NB_COEF;

    // one bank per window column
    localparam int NB_BANKS    = 3;
    localparam int NB_BANK_IDX = $clog2(NB_BANKS);
    localparam int BANK_DEPTH  = 2 ** NB_ADDRESS;

    // bank read, window shift, multiply, sum
    localparam int CONV_LATENCY = 4;
    // rows read before the first full window
    localparam int WINDOW_FILL  = 2;

    // laplacian edge detect, indexed [row][column]
    localparam logic signed [NB_COEF-1:0] KERNEL [NB_BANKS][NB_BANKS] = '{
        '{ 4'sd0, -4'sd1,  4'sd0},
        '{-4'sd1,  4'sd4, -4'sd1},
        '{ 4'sd0, -4'sd1,  4'sd0}
    };

    typedef struct packed {
        logic [NB_ADDRESS-1:0] wrAddr;
        logic [NB_BANKS-1:0]   wrSel;
        logic [NB_ADDRESS-1:0] rdAddr;
    } bankCtrl_t;

endpackage

`default_nettype wire

/* hw/frameSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module frameSequencer
    import convPkg::*;
(
    input  wire                          i_CLK,
    input  wire                          i_reset,
    input  wire                          i_load,
    input  wire                          i_SoP,
    input  wire                          i_pixValid,
    input  wire  [NB_ADDRESS-1:0]        i_imgLength,
    input  wire                          i_resultValid,
    output bankCtrl_t                    o_bankCtrl,
    output logic [NB_BANK_IDX-1:0]       o_oldestBank,
    output logic                         o_convValid,
    output logic [NB_ADDRESS-1:0]        o_resultWrAddr,
    output logic [NB_ADDRESS-1:0]        o_resultRdAddr,
    output logic                         o_EoP,
    output logic                         o_changeBlock
);

    typedef enum logic [1:0] {
        IDLE,
        LOAD_READ,
        PROCESS,
        WAIT_RELEASE
    } phase_t;

    phase_t                  phase;
    logic [NB_ADDRESS-1:0]   imgHeight;
    logic [NB_ADDRESS-1:0]   addrCount;
    logic [NB_ADDRESS-1:0]   wrCount;
    logic [NB_BANK_IDX-1:0]  wrPtr;
    logic                    pixValidQ;
    logic                    validRise;
    logic                    loading;
    logic                    tailDone;
    logic                    endOfProcess;
    logic                    changeBlock;
    logic                    convValid;
    logic                    bankWrite;
    logic                    lastResult;

    assign validRise  = i_pixValid && !pixValidQ;
    assign bankWrite  = (phase == LOAD_READ) && loading && validRise && !tailDone;
    assign lastResult = (wrCount == imgHeight - NB_ADDRESS'(2));

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            pixValidQ    <= 1'b0;
            phase        <= IDLE;
            imgHeight    <= i_imgLength;
            addrCount    <= '0;
            wrCount      <= '0;
            wrPtr        <= '0;
            loading      <= 1'b0;
            tailDone     <= 1'b0;
            endOfProcess <= 1'b0;
            changeBlock  <= 1'b0;
            convValid    <= 1'b0;
        end else begin
            pixValidQ   <= i_pixValid;
            changeBlock <= 1'b0;
            case (phase)
                IDLE: begin
                    addrCount <= '0;
                    tailDone  <= 1'b0;
                    if (i_load && !i_SoP && !endOfProcess) begin
                        loading <= 1'b1;
                        phase   <= LOAD_READ;
                    end else if (!i_load && i_SoP && !endOfProcess) begin
                        wrCount   <= '0;
                        convValid <= 1'b1;
                        phase     <= PROCESS;
                    end else if (!i_load && !i_SoP && endOfProcess) begin
                        // results ready, host reads them back
                        loading <= 1'b0;
                        phase   <= LOAD_READ;
                    end
                end
                LOAD_READ: begin
                    if (validRise && !tailDone) begin
                        if (addrCount == imgHeight) begin
                            tailDone <= 1'b1;
                        end else begin
                            addrCount <= addrCount + 1'b1;
                        end
                    end
                    if (tailDone && !i_load) begin
                        phase <= IDLE;
                        if (loading) begin
                            changeBlock <= 1'b1;
                            wrPtr <= (wrPtr == NB_BANK_IDX'(NB_BANKS - 1)) ? '0 : wrPtr + 1'b1;
                        end else begin
                            endOfProcess <= 1'b0;
                        end
                    end
                end
                PROCESS: begin
                    if (addrCount != imgHeight) begin
                        addrCount <= addrCount + 1'b1;
                    end else begin
                        convValid <= 1'b0;
                    end
                    // write side trails the reads by the convolver latency
                    if (i_resultValid) begin
                        if (lastResult) begin
                            endOfProcess <= 1'b1;
                            phase        <= WAIT_RELEASE;
                        end else begin
                            wrCount <= wrCount + 1'b1;
                        end
                    end
                end
                WAIT_RELEASE: begin
                    if (!i_SoP) begin
                        phase <= IDLE;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    assign o_bankCtrl = '{
        wrAddr: addrCount,
        wrSel:  bankWrite ? (NB_BANKS'(1) << wrPtr) : '0,
        rdAddr: addrCount
    };
    // next bank to overwrite holds the oldest column
    assign o_oldestBank   = wrPtr;
    assign o_convValid    = convValid;
    assign o_resultWrAddr = wrCount;
    assign o_resultRdAddr = addrCount;
    assign o_EoP          = endOfProcess;
    assign o_changeBlock  = changeBlock;

    // every pixel write lands in exactly one of the three banks
    wrSelOneHot: assert property (@(posedge i_CLK) disable iff (i_reset)
        bankWrite ? $onehot(o_bankCtrl.wrSel) : (o_bankCtrl.wrSel == '0));

    // first result lands a fixed number of cycles after the first read
    firstResultTiming: assert property (@(posedge i_CLK) disable iff (i_reset)
        $rose(o_convValid) |-> ##(CONV_LATENCY + WINDOW_FILL) $rose(i_resultValid));

    noResultAfterEoP: assert property (@(posedge i_CLK) disable iff (i_reset)
        o_EoP |-> !i_resultValid);

endmodule

`default_nettype wire

/* hw/kernelConvolver.sv */
`timescale 1ns/1ps
`default_nettype none

module kernelConvolver
    import convPkg::*;
(
    input  wire                                i_CLK,
    input  wire                                i_reset,
    input  wire  [NB_BANKS-1:0][NB_PIXEL-1:0]  i_columns,
    input  wire  [NB_BANK_IDX-1:0]             i_oldestBank,
    input  wire                                i_valid,
    output logic signed [NB_RESULT-1:0]        o_result,
    output logic                               o_resultValid
);

    logic                          validQ;
    logic [1:0]                    fillCount;
    logic                          winValid;
    logic                          prodValid;
    logic [NB_PIXEL-1:0]           ageCol [NB_BANKS];
    // window[column][row], row 0 is the top
    logic [NB_PIXEL-1:0]           window [NB_BANKS][NB_BANKS];
    logic signed [NB_PRODUCT-1:0]  product [NB_BANKS][NB_BANKS];
    logic signed [NB_RESULT-1:0]   productSum;

    // column 0 is the oldest loaded column
    always_comb begin
        int bankIdx;
        for (int c = 0; c < NB_BANKS; c++) begin
            bankIdx   = (int'(i_oldestBank) + c) % NB_BANKS;
            ageCol[c] = i_columns[bankIdx];
        end
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            validQ        <= 1'b0;
            fillCount     <= '0;
            winValid      <= 1'b0;
            prodValid     <= 1'b0;
            o_resultValid <= 1'b0;
        end else begin
            // bank data arrives one cycle after its read address
            validQ        <= i_valid;
            winValid      <= validQ && (fillCount == 2'(WINDOW_FILL));
            prodValid     <= winValid;
            o_resultValid <= prodValid;
            if (!validQ) begin
                fillCount <= '0;
            end else if (fillCount != 2'(WINDOW_FILL)) begin
                fillCount <= fillCount + 1'b1;
            end
        end
    end

    always_ff @(posedge i_CLK) begin
        if (validQ) begin
            for (int c = 0; c < NB_BANKS; c++) begin
                window[c][0] <= window[c][1];
                window[c][1] <= window[c][2];
                window[c][2] <= ageCol[c];
            end
        end
    end

    always_ff @(posedge i_CLK) begin
        for (int r = 0; r < NB_BANKS; r++) begin
            for (int c = 0; c < NB_BANKS; c++) begin
                product[r][c] <= $signed({1'b0, window[c][r]}) * KERNEL[r][c];
            end
        end
    end

    always_comb begin
        productSum = '0;
        for (int r = 0; r < NB_BANKS; r++) begin
            for (int c = 0; c < NB_BANKS; c++) begin
                productSum = productSum + NB_RESULT'(product[r][c]);
            end
        end
    end

    always_ff @(posedge i_CLK) begin
        o_result <= productSum;
    end

    // a result needs three consecutive rows behind it
    fullWindow: assert property (@(posedge i_CLK) disable iff (i_reset)
        o_resultValid |-> $past(validQ, 3) && $past(validQ, 4) && $past(validQ, 5));

endmodule

`default_nettype wire

/* hw/resultBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module resultBuffer
    import convPkg::*;
(
    input  wire                          i_CLK,
    input  wire                          i_wrEn,
    input  wire  [NB_ADDRESS-1:0]        i_wrAddr,
    input  wire  signed [NB_RESULT-1:0]  i_wrData,
    input  wire  [NB_ADDRESS-1:0]        i_rdAddr,
    output logic signed [NB_RESULT-1:0]  o_rdData
);

    logic signed [NB_RESULT-1:0] resultMem [BANK_DEPTH];

    always_ff @(posedge i_CLK) begin
        if (i_wrEn) begin
            resultMem[i_wrAddr] <= i_wrData;
        end
    end

    always_ff @(posedge i_CLK) begin
        o_rdData <= resultMem[i_rdAddr];
    end

    // results of a pass fill the buffer from the bottom without gaps
    burstStartsAtZero: assert property (@(posedge i_CLK)
        $rose(i_wrEn) |-> (i_wrAddr == '0));

    burstIsSequential: assert property (@(posedge i_CLK)
        i_wrEn && $past(i_wrEn) |-> (i_wrAddr == $past(i_wrAddr) + 1'b1));

endmodule

`default_nettype wire

/* tb/convColumnPatterns.txt */
// last row index, then four pixel columns, then expected results of two passes
// columns are listed top row first, results in hex as 20-bit two's complement
5
// column 0
10 20 30 40 50 60
// column 1
05 80 FF 00 7F 33
// column 2
22 11 44 33 66 55
// column 3
C8 01 9A 64 0F E0
// first pass on columns 0 to 2
000CB
00308
FFE0F
00113
// second pass on columns 1 to 3
FFF5D
FFF33
FFFBE
00082

/* tb/convColumnTb.sv */
`timescale 1ns/1ps
`default_nettype none

module convColumnTb
    import convPkg::*;
();

    localparam int RESET_CYCLES  = 8;
    localparam int MAX_HOLD      = 4;
    localparam int MAX_GAP       = 4;
    localparam int READ_SETTLE   = 4;
    localparam int PATTERN_WORDS = 33;

    logic                        i_CLK;
    logic                        i_reset;
    logic                        i_load;
    logic                        i_SoP;
    logic                        i_pixValid;
    logic [NB_PIXEL-1:0]         i_pixel;
    logic [NB_ADDRESS-1:0]       i_imgLength;
    wire signed [NB_RESULT-1:0]  o_result;
    wire                         o_EoP;
    wire                         o_changeBlock;

    logic [NB_RESULT-1:0] patternMem [PATTERN_WORDS];
    int imgLength;
    int changeCount = 0;
    int cycleCount = 0;
    int cycleLimit = 2000;

    convColumnTop UUT (
        .i_CLK         (i_CLK),
        .i_reset       (i_reset),
        .i_load        (i_load),
        .i_SoP         (i_SoP),
        .i_pixValid    (i_pixValid),
        .i_pixel       (i_pixel),
        .i_imgLength   (i_imgLength),
        .o_result      (o_result),
        .o_EoP         (o_EoP),
        .o_changeBlock (o_changeBlock)
    );

    initial begin
        i_CLK = 1'b0;
        forever #10 i_CLK = ~i_CLK;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
                              $time, name, actual, expected));
        end
    endtask

    // sampled on the rising edge, read on the falling edge
    always @(posedge i_CLK) begin
        cycleCount <= cycleCount + 1;
        if (!i_reset && o_changeBlock === 1'b1) begin
            changeCount <= changeCount + 1;
        end
        if (cycleCount >= cycleLimit) begin
            failRun($sformatf("timeout after %0d clock cycles", cycleLimit));
        end
    end

    function automatic int pixelAt(input int col, input int row);
        return int'(patternMem[1 + col * (imgLength + 1) + row][NB_PIXEL-1:0]);
    endfunction

    function automatic logic [NB_RESULT-1:0] expectedAt(input int pass, input int k);
        return patternMem[1 + 4 * (imgLength + 1) + pass * (imgLength - 1) + k];
    endfunction

    // window rows k..k+2 of columns pass..pass+2, oldest column first
    function automatic logic [NB_RESULT-1:0] modelResult(input int pass, input int k);
        int acc;
        acc = 0;
        for (int r = 0; r < NB_BANKS; r++) begin
            for (int c = 0; c < NB_BANKS; c++) begin
                acc = acc + pixelAt(pass + c, k + r) * int'(KERNEL[r][c]);
            end
        end
        return NB_RESULT'(acc);
    endfunction

    task automatic verifyPatterns();
        if ($isunknown(patternMem[0])) begin
            failRun("could not read tb/convColumnPatterns.txt");
        end
        imgLength = int'(patternMem[0]);
        if (imgLength < 2 || 1 + 4 * (imgLength + 1) + 2 * (imgLength - 1) != PATTERN_WORDS) begin
            failRun("bad pattern file, image length does not match the word count");
        end
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k <= imgLength - 2; k++) begin
                if (modelResult(p, k) !== expectedAt(p, k)) begin
                    failRun($sformatf("bad pattern file, pass %0d result %0d disagrees %s",
                                      p, k, "with the reference model"));
                end
            end
        end
    endtask

    // one valid pulse with random hold and idle time
    task automatic pulseValid();
        int holdCycles;
        int gapCycles;
        holdCycles = $urandom_range(MAX_HOLD, 1);
        gapCycles  = $urandom_range(MAX_GAP, 1);
        i_pixValid = 1'b1;
        repeat (holdCycles) @(negedge i_CLK);
        i_pixValid = 1'b0;
        repeat (gapCycles) @(negedge i_CLK);
    endtask

    task automatic loadColumn(input int col);
        int countBefore;
        countBefore = changeCount;
        i_load = 1'b1;
        @(negedge i_CLK);
        for (int row = 0; row <= imgLength; row++) begin
            i_pixel = NB_PIXEL'(pixelAt(col, row));
            pulseValid();
        end
        checkValue("o_changeBlock before i_load drops", changeCount, countBefore);
        i_load = 1'b0;
        while (changeCount == countBefore) begin
            @(negedge i_CLK);
        end
        repeat (3) @(negedge i_CLK);
        checkValue("o_changeBlock pulses per load", changeCount, countBefore + 1);
    endtask

    task automatic runPass();
        i_SoP = 1'b1;
        while (o_EoP !== 1'b1) begin
            @(negedge i_CLK);
        end
        i_SoP = 1'b0;
        repeat (READ_SETTLE) @(negedge i_CLK);
    endtask

    task automatic readResults(input int pass);
        checkValue("o_EoP at read start", o_EoP, 1'b1);
        checkValue("o_result[0]", $unsigned(o_result), expectedAt(pass, 0));
        // pulses past the last result walk the address to the end
        for (int k = 1; k <= imgLength + 1; k++) begin
            pulseValid();
            if (k <= imgLength - 2) begin
                checkValue($sformatf("o_result[%0d]", k), $unsigned(o_result),
                           expectedAt(pass, k));
            end
        end
        @(negedge i_CLK);
        checkValue("o_EoP after read", o_EoP, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h3a6));
        i_reset     = 1'b1;
        i_load      = 1'b0;
        i_SoP       = 1'b0;
        i_pixValid  = 1'b0;
        i_pixel     = '0;
        i_imgLength = '0;
        $readmemh("tb/convColumnPatterns.txt", patternMem);
        verifyPatterns();
        i_imgLength = NB_ADDRESS'(imgLength);
        // four loads, one pass and one read at worst spacing, doubled
        cycleLimit = 2 * (RESET_CYCLES
                          + 4 * ((imgLength + 1) * (MAX_HOLD + MAX_GAP) + 5)
                          + (imgLength + 1 + CONV_LATENCY + WINDOW_FILL + READ_SETTLE + 2)
                          + ((imgLength + 1) * (MAX_HOLD + MAX_GAP) + 1));
        repeat (RESET_CYCLES) @(negedge i_CLK);
        i_reset = 1'b0;
        checkValue("o_EoP after reset", o_EoP, 1'b0);
        checkValue("o_changeBlock after reset", o_changeBlock, 1'b0);

        for (int col = 0; col < NB_BANKS; col++) begin
            loadColumn(col);
        end
        runPass();
        readResults(0);

        // fourth column overwrites the oldest bank
        loadColumn(3);
        runPass();
        readResults(1);

        checkValue("o_changeBlock pulses in total", changeCount, 4);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
